//--- Bender.yml
package:
  name: sb_scoreboard

sources:
  - include_dirs:
      - common
    files:
      - common/sb_pkg.sv
      - scoreboard/sb_queue.sv
      - scoreboard/sb_clobber.sv
      - scoreboard/sb_forward.sv
      - design/sb_top.sv
      - target: test
        files:
          - dv/tb_clk_gen.sv
          - dv/sb_sva.sv
          - dv/sb_checker.sv
          - dv/sb_tb.sv

//--- common/sb_defs.svh
`ifndef SB_DEFS_SVH
`define SB_DEFS_SVH

// scoreboard queue depth
// must stay a power of two so the insert counter saturates at all ones
`define SB_NR_ENTRIES 8

// width of a slot index, also used as transaction id
`define SB_IDX_W 3

// register file geometry
`define SB_REG_AW 5
`define SB_NR_REGS 32

// operand and result width
`define SB_DATA_W 32

`endif

//--- common/sb_pkg.sv
`include "sb_defs.svh"

package sb_pkg;

  // functional unit that executes an instruction
  // FU_NONE entries finish on their own without write-back
  typedef enum logic [1:0] {
    FU_NONE = 2'd0,
    FU_ALU  = 2'd1,
    FU_LOAD = 2'd2
  } fu_e;

  // decoded instruction as seen by issue and commit
  typedef struct packed {
    fu_e                   fu;
    logic [`SB_REG_AW-1:0] rd;
    logic [`SB_REG_AW-1:0] rs1;
    logic [`SB_REG_AW-1:0] rs2;
    logic [`SB_IDX_W-1:0]  trans_id;
    logic [`SB_DATA_W-1:0] result;
    // instruction has produced its result
    logic                  done;
  } sb_entry_t;

  // single write-back port from the execution units
  typedef struct packed {
    logic                  valid;
    logic [`SB_IDX_W-1:0]  trans_id;
    logic [`SB_DATA_W-1:0] data;
  } wb_t;

  // one queue slot with its bookkeeping flags
  typedef struct packed {
    logic      valid;
    logic      issued;
    sb_entry_t entry;
  } slot_t;

endpackage

//--- design/sb_top.sv
`timescale 1ns/10ps
`include "sb_defs.svh"

module sb_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // decoder
  input  sb_pkg::sb_entry_t             decoded_i,
  input  logic                          decoded_valid_i,
  output logic                          decoded_ack_o,
  // issue stage
  output sb_pkg::sb_entry_t             issue_o,
  output logic                          issue_valid_o,
  input  logic                          issue_ack_i,
  // execution units
  input  sb_pkg::wb_t                   wb_i,
  // commit stage
  output sb_pkg::sb_entry_t             commit_o,
  input  logic                          commit_ack_i,
  input  logic                          flush_i,
  output logic                          sb_full_o,
  // pending destination registers
  output logic [`SB_NR_REGS-1:0]        rd_clobber_o,
  // operand read
  input  logic [`SB_REG_AW-1:0]         rs1_i,
  output logic [`SB_DATA_W-1:0]         rs1_o,
  output logic                          rs1_valid_o,
  input  logic [`SB_REG_AW-1:0]         rs2_i,
  output logic [`SB_DATA_W-1:0]         rs2_o,
  output logic                          rs2_valid_o
);

  sb_pkg::slot_t [`SB_NR_ENTRIES-1:0] slots;
  sb_pkg::wb_t                        wb_fwd;

  sb_queue i_queue (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .decoded_i       ( decoded_i       ),
    .decoded_valid_i ( decoded_valid_i ),
    .decoded_ack_o   ( decoded_ack_o   ),
    .issue_o         ( issue_o         ),
    .issue_valid_o   ( issue_valid_o   ),
    .issue_ack_i     ( issue_ack_i     ),
    .wb_i            ( wb_i            ),
    .commit_o        ( commit_o        ),
    .commit_ack_i    ( commit_ack_i    ),
    .flush_i         ( flush_i         ),
    .sb_full_o       ( sb_full_o       ),
    .slots_o         ( slots           ),
    .wb_o            ( wb_fwd          )
  );

  sb_clobber i_clobber (
    .slots_i   ( slots        ),
    .clobber_o ( rd_clobber_o )
  );

  sb_forward i_forward (
    .slots_i     ( slots       ),
    .wb_i        ( wb_fwd      ),
    .rs1_i       ( rs1_i       ),
    .rs2_i       ( rs2_i       ),
    .rs1_o       ( rs1_o       ),
    .rs1_valid_o ( rs1_valid_o ),
    .rs2_o       ( rs2_o       ),
    .rs2_valid_o ( rs2_valid_o )
  );

endmodule

//--- dv/sb_checker.sv
`timescale 1ns/10ps
`include "sb_defs.svh"

module sb_checker (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic [2:0]             test_id_i,
  input sb_pkg::sb_entry_t      decoded_i,
  input logic                   decoded_valid_i,
  input logic                   decoded_ack_i,
  input sb_pkg::sb_entry_t      issue_i,
  input logic                   issue_valid_i,
  input logic                   issue_ack_i,
  input sb_pkg::wb_t            wb_i,
  input sb_pkg::sb_entry_t      commit_i,
  input logic                   commit_ack_i,
  input logic                   flush_i,
  input logic                   sb_full_i,
  input logic [`SB_NR_REGS-1:0] clobber_i,
  input logic [`SB_REG_AW-1:0]  rs1_i,
  input logic [`SB_REG_AW-1:0]  rs2_i,
  // {valid, data} of each read port
  input logic [`SB_DATA_W:0]    rs1_fwd_i,
  input logic [`SB_DATA_W:0]    rs2_fwd_i
);

  // --------------------
  // model queue
  // --------------------
  logic [`SB_NR_ENTRIES-1:0] m_valid, m_issued, m_done;
  logic [`SB_REG_AW-1:0]     m_rd [`SB_NR_ENTRIES];
  sb_pkg::fu_e               m_fu [`SB_NR_ENTRIES];
  logic [`SB_DATA_W-1:0]     m_res [`SB_NR_ENTRIES];
  logic [`SB_IDX_W-1:0]      m_ins, m_iss, m_com, m_cnt, m_icnt;
  logic                      exp_full, exp_synced, exp_ack, exp_ins, exp_iss, wb_hit;

  int unsigned err_cnt  = 0;
  int unsigned chk_cnt  = 0;
  int unsigned err_base = 0;
  logic [2:0]  last_test = 3'd0;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "order";
      3'd2:    return "full";
      3'd3:    return "wb_commit";
      3'd4:    return "forward";
      3'd5:    return "clobber";
      3'd6:    return "flush";
      default: return "none";
    endcase
  endfunction

  // reference for forwarding, write-back first then lowest slot
  function automatic logic [`SB_DATA_W:0] exp_fwd(input logic [`SB_REG_AW-1:0] rs);
    if (rs == '0) begin
      return '0;
    end
    if (wb_i.valid && m_issued[wb_i.trans_id] && m_rd[wb_i.trans_id] == rs) begin
      return {1'b1, wb_i.data};
    end
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (m_issued[i] && m_done[i] && m_rd[i] == rs) begin
        return {1'b1, m_res[i]};
      end
    end
    return '0;
  endfunction

  // reference clobber vector, issued entries up to commit
  function automatic logic [`SB_NR_REGS-1:0] exp_clobber();
    logic [`SB_NR_REGS-1:0] c;
    c = '0;
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (m_issued[i] && m_rd[i] != '0) begin
        c[m_rd[i]] = 1'b1;
      end
    end
    return c;
  endfunction

  task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("Error: test %s, %s expected %0h actual %0h",
               test_name(test_id_i), what, exp, act);
    end
  endtask

  task automatic check_read(input string what, input logic [`SB_REG_AW-1:0] rs,
                            input logic [`SB_DATA_W:0] act);
    logic [`SB_DATA_W:0] exp;
    exp = exp_fwd(rs);
    compare({what, " valid"}, exp[`SB_DATA_W], act[`SB_DATA_W]);
    if (exp[`SB_DATA_W]) begin
      compare({what, " data"}, exp[`SB_DATA_W-1:0], act[`SB_DATA_W-1:0]);
    end
  endtask

  // --------------------
  // compare and step
  // --------------------
  // inputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (test_id_i != last_test) begin
      if (last_test != 3'd0 && err_cnt == err_base) begin
        $display("test %s: pass", test_name(last_test));
      end else if (last_test != 3'd0) begin
        $display("test %s: fail, %0d errors", test_name(last_test), err_cnt - err_base);
      end
      last_test = test_id_i;
      err_base  = err_cnt;
    end
    if (!rst_ni) begin
      m_valid  = '0;
      m_issued = '0;
      m_done   = '0;
      m_ins    = '0;
      m_iss    = '0;
      m_com    = '0;
      m_cnt    = '0;
      m_icnt   = '0;
    end else begin
      // queue holds at most depth minus one
      exp_full   = (m_cnt == '1);
      exp_synced = (m_cnt == m_icnt);
      exp_ack    = !exp_full && (!exp_synced || issue_ack_i);
      compare("sb_full", exp_full, sb_full_i);
      compare("decoded_ack", exp_ack, decoded_ack_i);
      compare("issue_valid", decoded_valid_i && !exp_full, issue_valid_i);
      if (issue_valid_i) begin
        compare("issue trans_id", m_ins, issue_i.trans_id);
        // bypass shows the decoder, else the oldest unissued entry
        compare("issue rd", exp_synced ? decoded_i.rd : m_rd[m_iss], issue_i.rd);
        compare("issue fu", exp_synced ? decoded_i.fu : m_fu[m_iss], issue_i.fu);
      end
      if (m_valid[m_com]) begin
        compare("commit trans_id", m_com, commit_i.trans_id);
        compare("commit rd", m_rd[m_com], commit_i.rd);
        compare("commit done", m_done[m_com], commit_i.done);
        if (m_done[m_com]) begin
          compare("commit result", m_res[m_com], commit_i.result);
        end
      end
      compare("clobber", exp_clobber(), clobber_i);
      check_read("rs1", rs1_i, rs1_fwd_i);
      check_read("rs2", rs2_i, rs2_fwd_i);

      // next state, same order as the edge applies it
      exp_ins = decoded_valid_i && exp_ack;
      exp_iss = issue_ack_i && (!exp_synced || exp_ins);
      wb_hit  = wb_i.valid && m_issued[wb_i.trans_id];
      for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
        if (m_valid[i] && m_fu[i] == sb_pkg::FU_NONE) begin
          m_done[i] = 1'b1;
        end
      end
      if (exp_ins) begin
        m_valid[m_ins]  = 1'b1;
        m_issued[m_ins] = 1'b0;
        m_done[m_ins]   = 1'b0;
        m_rd[m_ins]     = decoded_i.rd;
        m_fu[m_ins]     = decoded_i.fu;
        m_res[m_ins]    = decoded_i.result;
      end
      if (exp_iss) begin
        m_issued[m_iss] = 1'b1;
      end
      if (wb_hit) begin
        m_done[wb_i.trans_id] = 1'b1;
        m_res[wb_i.trans_id]  = wb_i.data;
      end
      if (commit_ack_i) begin
        m_valid[m_com]  = 1'b0;
        m_issued[m_com] = 1'b0;
        m_done[m_com]   = 1'b0;
      end
      m_ins  = m_ins + exp_ins;
      m_iss  = m_iss + exp_iss;
      m_com  = m_com + commit_ack_i;
      m_cnt  = m_cnt + exp_ins - commit_ack_i;
      m_icnt = m_icnt + exp_iss - commit_ack_i;
      if (flush_i) begin
        m_valid  = '0;
        m_issued = '0;
        m_done   = '0;
        m_ins    = '0;
        m_iss    = '0;
        m_com    = '0;
        m_cnt    = '0;
        m_icnt   = '0;
      end
    end
  end

endmodule

//--- dv/sb_sva.sv
`timescale 1ns/10ps
`include "sb_defs.svh"

module sb_sva (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic [`SB_NR_REGS-1:0]  clobber_i,
  input sb_pkg::sb_entry_t       commit_i,
  input logic                    commit_ack_i,
  input logic                    issue_ack_i,
  input logic                    issue_valid_i
);

  // failed assertions, read by the testbench top
  int unsigned fail_cnt = 0;

  // x0 is never pending
  a_x0_clobber: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !clobber_i[0])
    else begin
      fail_cnt++;
      $error("clobber bit of x0 is set");
    end

  // only a finished entry may retire
  a_commit_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i |-> commit_i.done)
    else begin
      fail_cnt++;
      $error("commit acknowledged on an unfinished entry");
    end

  a_issue_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ack_i |-> issue_valid_i)
    else begin
      fail_cnt++;
      $error("issue acknowledged without issue valid");
    end

endmodule

//--- dv/sb_tb.sv
`timescale 1ns/10ps
`include "sb_defs.svh"

module sb_tb;

  // six tests of at most 40 cycles, plus margin
  localparam int MAX_CYCLES = 6 * 40 + 160;

  logic                   clk, rst_n;
  sb_pkg::sb_entry_t      decoded, issue, commit;
  logic                   decoded_valid, decoded_ack, issue_valid, issue_ack;
  sb_pkg::wb_t            wb;
  logic                   commit_ack, flush, sb_full;
  logic [`SB_NR_REGS-1:0] rd_clobber;
  logic [`SB_REG_AW-1:0]  rs1, rs2;
  logic [`SB_DATA_W-1:0]  rs1_data, rs2_data;
  logic                   rs1_valid, rs2_valid;
  logic [2:0]             test_id;
  logic [31:0]            lfsr = 32'h60d1_5de4;
  int unsigned            cycles = 0;
  int unsigned            errors;
  // trans ids handed out at issue, oldest first
  logic [`SB_IDX_W-1:0]   pend_ids [$];

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(4)) i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  sb_top i_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .decoded_i (decoded), .decoded_valid_i (decoded_valid), .decoded_ack_o (decoded_ack),
    .issue_o (issue), .issue_valid_o (issue_valid), .issue_ack_i (issue_ack),
    .wb_i (wb), .commit_o (commit), .commit_ack_i (commit_ack), .flush_i (flush),
    .sb_full_o (sb_full), .rd_clobber_o (rd_clobber),
    .rs1_i (rs1), .rs1_o (rs1_data), .rs1_valid_o (rs1_valid),
    .rs2_i (rs2), .rs2_o (rs2_data), .rs2_valid_o (rs2_valid)
  );

  bind sb_top sb_sva i_sva (
    .clk_i (clk_i), .rst_ni (rst_ni), .clobber_i (rd_clobber_o), .commit_i (commit_o),
    .commit_ack_i (commit_ack_i), .issue_ack_i (issue_ack_i), .issue_valid_i (issue_valid_o)
  );

  sb_checker i_chk (
    .clk_i (clk), .rst_ni (rst_n), .test_id_i (test_id),
    .decoded_i (decoded), .decoded_valid_i (decoded_valid), .decoded_ack_i (decoded_ack),
    .issue_i (issue), .issue_valid_i (issue_valid), .issue_ack_i (issue_ack),
    .wb_i (wb), .commit_i (commit), .commit_ack_i (commit_ack), .flush_i (flush),
    .sb_full_i (sb_full), .clobber_i (rd_clobber), .rs1_i (rs1), .rs2_i (rs2),
    .rs1_fwd_i ({rs1_valid, rs1_data}), .rs2_fwd_i ({rs2_valid, rs2_data})
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  // --------------------
  // stimulus tasks
  // --------------------
  // defaults, the caller overrides after this
  task automatic clear_inputs();
    decoded_valid <= 1'b0;
    issue_ack     <= 1'b0;
    wb            <= '0;
    commit_ack    <= 1'b0;
    flush         <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      clear_inputs();
    end
  endtask

  task automatic start_test(input logic [2:0] id);
    @(posedge clk);
    clear_inputs();
    test_id <= id;
  endtask

  task automatic set_reads(input logic [`SB_REG_AW-1:0] a, input logic [`SB_REG_AW-1:0] b);
    @(posedge clk);
    clear_inputs();
    rs1 <= a;
    rs2 <= b;
  endtask

  // insert and issue in the same handshake
  task automatic insert_issue(input sb_pkg::fu_e fu, input logic [`SB_REG_AW-1:0] rd);
    sb_pkg::sb_entry_t d;
    d    = '0;
    d.fu = fu;
    d.rd = rd;
    @(posedge clk);
    clear_inputs();
    decoded       <= d;
    decoded_valid <= 1'b1;
    issue_ack     <= 1'b1;
    @(negedge clk);
    while (!decoded_ack) @(negedge clk);
    pend_ids.push_back(issue.trans_id);
  endtask

  task automatic write_back(input logic [`SB_IDX_W-1:0] tid);
    logic [31:0] data;
    rand_word(data);
    @(posedge clk);
    clear_inputs();
    wb <= '{valid: 1'b1, trans_id: tid, data: data};
  endtask

  task automatic commit_oldest();
    @(posedge clk);
    clear_inputs();
    @(negedge clk);
    while (!commit.done) @(negedge clk);
    @(posedge clk);
    clear_inputs();
    commit_ack <= 1'b1;
    void'(pend_ids.pop_front());
  endtask

  task automatic do_flush();
    @(posedge clk);
    clear_inputs();
    flush <= 1'b1;
    pend_ids.delete();
  endtask

  // --------------------
  // tests
  // --------------------
  initial begin
    decoded       = '0;
    decoded_valid = 1'b0;
    issue_ack     = 1'b0;
    wb            = '0;
    commit_ack    = 1'b0;
    flush         = 1'b0;
    rs1           = '0;
    rs2           = '0;
    test_id       = 3'd0;
    wait (rst_n);

    // ids walk 0..7 and wrap
    start_test(3'd1);
    for (int i = 0; i < 10; i++) begin
      insert_issue(sb_pkg::FU_NONE, `SB_REG_AW'(i + 1));
      commit_oldest();
    end
    idle(1);

    start_test(3'd2);
    for (int i = 0; i < 7; i++) begin
      insert_issue(sb_pkg::FU_ALU, `SB_REG_AW'(20 + i));
    end
    // decoder knocks while full, no issue ack
    @(posedge clk);
    clear_inputs();
    decoded_valid <= 1'b1;
    idle(1);
    for (int i = 0; i < 7; i++) begin
      write_back(pend_ids[0]);
      commit_oldest();
    end
    idle(1);

    // out-of-order completion, in-order commit
    start_test(3'd3);
    insert_issue(sb_pkg::FU_ALU, 5'd5);
    insert_issue(sb_pkg::FU_NONE, 5'd6);
    insert_issue(sb_pkg::FU_ALU, 5'd7);
    write_back(pend_ids[2]);
    write_back(pend_ids[0]);
    repeat (3) commit_oldest();
    idle(1);

    start_test(3'd4);
    set_reads(5'd9, 5'd0);
    insert_issue(sb_pkg::FU_ALU, 5'd9);
    insert_issue(sb_pkg::FU_ALU, 5'd0);
    write_back(pend_ids[0]);
    write_back(pend_ids[1]);
    set_reads(5'd0, 5'd9);
    idle(1);
    repeat (2) commit_oldest();
    set_reads(5'd0, 5'd0);

    start_test(3'd5);
    insert_issue(sb_pkg::FU_ALU, 5'd3);
    insert_issue(sb_pkg::FU_ALU, 5'd4);
    insert_issue(sb_pkg::FU_ALU, 5'd0);
    idle(1);
    for (int i = 0; i < 3; i++) begin
      write_back(pend_ids[i]);
    end
    repeat (3) commit_oldest();
    idle(1);

    start_test(3'd6);
    insert_issue(sb_pkg::FU_ALU, 5'd10);
    insert_issue(sb_pkg::FU_ALU, 5'd11);
    insert_issue(sb_pkg::FU_ALU, 5'd12);
    write_back(pend_ids[1]);
    do_flush();
    idle(1);
    insert_issue(sb_pkg::FU_ALU, 5'd13);
    write_back(pend_ids[0]);
    commit_oldest();
    idle(1);

    // let the checker close the last test
    start_test(3'd7);
    @(negedge clk);
    #1;
    errors = i_chk.err_cnt + i_dut.i_sva.fail_cnt;
    $display("tests: 6, checks: %0d, errors: %0d", i_chk.chk_cnt, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release lands between a falling and a rising edge
  initial begin
    rst_no = 1'b0;
    #(RST_CYCLES * PERIOD_NS + PERIOD_NS / 4);
    rst_no = 1'b1;
  end

endmodule

//--- files.f
+incdir+common
common/sb_pkg.sv
scoreboard/sb_queue.sv
scoreboard/sb_clobber.sv
scoreboard/sb_forward.sv
design/sb_top.sv
dv/tb_clk_gen.sv
dv/sb_sva.sv
dv/sb_checker.sv
dv/sb_tb.sv

//--- scoreboard/sb_clobber.sv
`timescale 1ns/10ps
`include "sb_defs.svh"

module sb_clobber (
  input  sb_pkg::slot_t [`SB_NR_ENTRIES-1:0] slots_i,
  output logic [`SB_NR_REGS-1:0]             clobber_o
);

  // per register, which slots write it
  logic [`SB_NR_REGS-1:0][`SB_NR_ENTRIES-1:0] clobber_vld;

  always_comb begin
    clobber_vld = '0;
    // an entry holds its rd from issue until commit
    for (int unsigned i = 0; i < `SB_NR_ENTRIES; i++) begin
      clobber_vld[slots_i[i].entry.rd][i] = slots_i[i].issued;
    end
  end

  always_comb begin
    clobber_o = '0;
    for (int unsigned r = 0; r < `SB_NR_REGS; r++) begin
      clobber_o[r] = |clobber_vld[r];
    end
    // x0 is hardwired and never pending
    clobber_o[0] = 1'b0;
  end

endmodule

//--- scoreboard/sb_forward.sv
`timescale 1ns/10ps
`include "sb_defs.svh"

module sb_forward (
  input  sb_pkg::slot_t [`SB_NR_ENTRIES-1:0] slots_i,
  input  sb_pkg::wb_t                        wb_i,
  input  logic [`SB_REG_AW-1:0]              rs1_i,
  input  logic [`SB_REG_AW-1:0]              rs2_i,
  output logic [`SB_DATA_W-1:0]              rs1_o,
  output logic                               rs1_valid_o,
  output logic [`SB_DATA_W-1:0]              rs2_o,
  output logic                               rs2_valid_o
);

  // request 0 is the write-back port, slot k is request k+1
  logic [`SB_NR_ENTRIES:0]                 rs1_req, rs2_req;
  logic [`SB_NR_ENTRIES:0][`SB_DATA_W-1:0] rs_data;
  logic [`SB_DATA_W:0]                     rs1_sel, rs2_sel;
  logic                                    wb_hit;

  // fixed priority pick, lowest request index wins
  // returns {valid, data}
  function automatic logic [`SB_DATA_W:0] pick_first(
    input logic [`SB_NR_ENTRIES:0]                 req,
    input logic [`SB_NR_ENTRIES:0][`SB_DATA_W-1:0] data
  );
    logic [`SB_DATA_W:0] sel;
    sel = '0;
    // walk down so the lowest index is written last
    for (int i = `SB_NR_ENTRIES; i >= 0; i--) begin
      if (req[i]) begin
        sel = {1'b1, data[i]};
      end
    end
    return sel;
  endfunction

  // write-back targets a live issued entry
  assign wb_hit = wb_i.valid & slots_i[wb_i.trans_id].issued;

  always_comb begin
    rs1_req[0] = wb_hit & (slots_i[wb_i.trans_id].entry.rd == rs1_i);
    rs2_req[0] = wb_hit & (slots_i[wb_i.trans_id].entry.rd == rs2_i);
    rs_data[0] = wb_i.data;
    // finished entries still waiting for commit
    for (int unsigned k = 0; k < `SB_NR_ENTRIES; k++) begin
      rs1_req[k+1] = slots_i[k].issued & slots_i[k].entry.done &
                     (slots_i[k].entry.rd == rs1_i);
      rs2_req[k+1] = slots_i[k].issued & slots_i[k].entry.done &
                     (slots_i[k].entry.rd == rs2_i);
      rs_data[k+1] = slots_i[k].entry.result;
    end
  end

  assign rs1_sel = pick_first(rs1_req, rs_data);
  assign rs2_sel = pick_first(rs2_req, rs_data);

  assign rs1_o       = rs1_sel[`SB_DATA_W-1:0];
  assign rs2_o       = rs2_sel[`SB_DATA_W-1:0];
  // x0 is never forwarded
  assign rs1_valid_o = rs1_sel[`SB_DATA_W] & (|rs1_i);
  assign rs2_valid_o = rs2_sel[`SB_DATA_W] & (|rs2_i);

endmodule

//--- scoreboard/sb_queue.sv
`timescale 1ns/10ps
`include "sb_defs.svh"

module sb_queue (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // decoder side
  input  sb_pkg::sb_entry_t                       decoded_i,
  input  logic                                    decoded_valid_i,
  output logic                                    decoded_ack_o,
  // issue side
  output sb_pkg::sb_entry_t                       issue_o,
  output logic                                    issue_valid_o,
  input  logic                                    issue_ack_i,
  // write-back and commit
  input  sb_pkg::wb_t                             wb_i,
  output sb_pkg::sb_entry_t                       commit_o,
  input  logic                                    commit_ack_i,
  input  logic                                    flush_i,
  output logic                                    sb_full_o,
  // state towards clobber and forwarding logic
  output sb_pkg::slot_t [`SB_NR_ENTRIES-1:0]      slots_o,
  output sb_pkg::wb_t                             wb_o
);

  sb_pkg::slot_t [`SB_NR_ENTRIES-1:0] mem_q, mem_n;

  logic                 insert_full, insert_synced;
  logic                 insert_en, issue_en;
  logic [`SB_IDX_W-1:0] insert_ptr_q, insert_ptr_n;
  logic [`SB_IDX_W-1:0] issue_ptr_q, issue_ptr_n;
  logic [`SB_IDX_W-1:0] commit_ptr_q, commit_ptr_n;
  logic [`SB_IDX_W-1:0] insert_cnt_q, insert_cnt_n;
  logic [`SB_IDX_W-1:0] issue_cnt_q, issue_cnt_n;

  // counter saturates at all ones, one slot always stays free
  assign insert_full = &insert_cnt_q;
  assign sb_full_o   = insert_full;

  // nothing unissued sits in the queue
  assign insert_synced = (insert_cnt_q == issue_cnt_q);

  // --------------------
  // issue handshake
  // --------------------
  always_comb begin
    // bypass the decoder straight to issue when queue has no backlog
    issue_o          = insert_synced ? decoded_i : mem_q[issue_ptr_q].entry;
    issue_o.trans_id = insert_ptr_q;
    issue_valid_o    = decoded_valid_i & ~insert_full;
    // on bypass the decoder must also wait for the issue stage
    decoded_ack_o    = ~insert_full & (~insert_synced | issue_ack_i);
  end

  assign insert_en = decoded_valid_i & decoded_ack_o;
  // with bypass an issue only happens together with an insert
  assign issue_en  = issue_ack_i & (~insert_synced | insert_en);

  // oldest entry shown to commit
  always_comb begin
    commit_o          = mem_q[commit_ptr_q].entry;
    commit_o.trans_id = commit_ptr_q;
  end

  // --------------------
  // slot update
  // --------------------
  // later steps override earlier ones
  always_comb begin
    mem_n = mem_q;

    // insert new entry, id is its slot index
    if (insert_en) begin
      mem_n[insert_ptr_q].valid          = 1'b1;
      mem_n[insert_ptr_q].issued         = 1'b0;
      mem_n[insert_ptr_q].entry          = decoded_i;
      mem_n[insert_ptr_q].entry.trans_id = insert_ptr_q;
      mem_n[insert_ptr_q].entry.done     = 1'b0;
    end

    // mark handed-over entry as issued
    if (issue_en) begin
      mem_n[issue_ptr_q].issued = 1'b1;
    end

    // no functional unit means nothing to wait for
    for (int unsigned i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (mem_q[i].valid && mem_q[i].entry.fu == sb_pkg::FU_NONE) begin
        mem_n[i].entry.done = 1'b1;
      end
    end

    // write-back only lands on issued entries
    // a stale result after flush is dropped here
    if (wb_i.valid && mem_q[wb_i.trans_id].issued) begin
      mem_n[wb_i.trans_id].entry.done   = 1'b1;
      mem_n[wb_i.trans_id].entry.result = wb_i.data;
    end

    // retire the oldest entry
    if (commit_ack_i) begin
      mem_n[commit_ptr_q].valid      = 1'b0;
      mem_n[commit_ptr_q].issued     = 1'b0;
      mem_n[commit_ptr_q].entry.done = 1'b0;
    end

    // full flush drops every entry
    if (flush_i) begin
      for (int unsigned i = 0; i < `SB_NR_ENTRIES; i++) begin
        mem_n[i].valid      = 1'b0;
        mem_n[i].issued     = 1'b0;
        mem_n[i].entry.done = 1'b0;
      end
    end
  end

  // --------------------
  // pointers and counters
  // --------------------
  // wrap is implicit since depth is a power of two
  assign insert_ptr_n = flush_i ? '0 : insert_ptr_q + `SB_IDX_W'(insert_en);
  assign issue_ptr_n  = flush_i ? '0 : issue_ptr_q + `SB_IDX_W'(issue_en);
  assign commit_ptr_n = flush_i ? '0 : commit_ptr_q + `SB_IDX_W'(commit_ack_i);
  assign insert_cnt_n = flush_i ? '0 :
                        insert_cnt_q - `SB_IDX_W'(commit_ack_i) + `SB_IDX_W'(insert_en);
  assign issue_cnt_n  = flush_i ? '0 :
                        issue_cnt_q - `SB_IDX_W'(commit_ack_i) + `SB_IDX_W'(issue_en);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q        <= '0;
      insert_ptr_q <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      insert_cnt_q <= '0;
      issue_cnt_q  <= '0;
    end else begin
      mem_q        <= mem_n;
      insert_ptr_q <= insert_ptr_n;
      issue_ptr_q  <= issue_ptr_n;
      commit_ptr_q <= commit_ptr_n;
      insert_cnt_q <= insert_cnt_n;
      issue_cnt_q  <= issue_cnt_n;
    end
  end

  // state for clobber and forwarding
  assign slots_o = mem_q;
  // same-cycle write-back for forwarding
  assign wb_o    = wb_i;

endmodule
